/* source/bus_pkg.sv */
package bus_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int data_bytes = data_width / 8;

    // beats minus one, enough for a full line
    localparam int len_width = 2;

    // top address bit selects the bypass
    localparam int uncached_bit = 31;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] word_t;
    typedef logic [data_bytes-1:0] wrten_t;
    typedef logic [len_width-1:0]  len_t;

    localparam wrten_t full_strobe = '1;

endpackage

/* source/cache_pkg.sv */
package cache_pkg;

    localparam int num_ways    = 4;
    localparam int way_bits    = $clog2(num_ways);
    localparam int index_bits  = 2;
    localparam int offset_bits = 2;
    localparam int align_bits  = 2;
    localparam int tag_bits    = bus_pkg::addr_width - index_bits - offset_bits - align_bits;

    localparam int num_sets  = 2 ** index_bits;
    localparam int num_words = 2 ** offset_bits;

    // data array holds every word of every way
    localparam int data_depth_bits = way_bits + index_bits + offset_bits;

    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [way_bits-1:0]    way_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [align_bits-1:0] zeros;
    } line_addr_t;

    typedef logic [num_ways-2:0] select_t;

    typedef struct packed {
        logic valid;
        logic dirty;
    } record_t;

    typedef tag_t [num_ways-1:0] bundle_t;
    typedef bus_pkg::word_t [num_words-1:0] line_t;

endpackage

/* source/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram #(
    parameter type payload_t  = logic [31:0],
    parameter int  depth_bits = 4,
    // write enables split the payload into this many equal lanes
    parameter int  lanes      = 1
) (
    input  logic                  clk,
    input  logic                  en_a,
    input  logic [lanes-1:0]      we_a,
    input  logic [depth_bits-1:0] addr_a,
    input  payload_t              wdata_a,
    output payload_t              rdata_a,
    input  logic                  en_b,
    input  logic [lanes-1:0]      we_b,
    input  logic [depth_bits-1:0] addr_b,
    input  payload_t              wdata_b,
    output payload_t              rdata_b
);
    localparam int lane_width = $bits(payload_t) / lanes;

    typedef logic [lanes-1:0][lane_width-1:0] entry_t;

    entry_t mem [2**depth_bits];
    entry_t wdata_a_lanes;
    entry_t wdata_b_lanes;

    assign wdata_a_lanes = wdata_a;
    assign wdata_b_lanes = wdata_b;

    // read-first on both ports, port b wins a same-entry write
    always_ff @(posedge clk) begin
        if (en_a) begin
            rdata_a <= payload_t'(mem[addr_a]);
            for (int i = 0; i < lanes; i++) begin
                if (we_a[i]) begin
                    mem[addr_a][i] <= wdata_a_lanes[i];
                end
            end
        end
        if (en_b) begin
            rdata_b <= payload_t'(mem[addr_b]);
            for (int i = 0; i < lanes; i++) begin
                if (we_b[i]) begin
                    mem[addr_b][i] <= wdata_b_lanes[i];
                end
            end
        end
    end

endmodule

/* source/plru_tree.sv */
`timescale 1ns/1ps

module plru_tree (
    input  cache_pkg::select_t select,
    output cache_pkg::way_t    victim,
    input  cache_pkg::way_t    touch_way,
    output cache_pkg::select_t new_select
);
    import cache_pkg::*;

    // node n has children 2n+1 and 2n+2, a set bit means go right
    always_comb begin
        int node;
        node   = 0;
        victim = '0;
        for (int l = 0; l < way_bits; l++) begin
            victim[way_bits-1-l] = select[node];
            node = 2 * node + 1 + int'(select[node]);
        end
    end

    // every node on the touched path points away from it
    always_comb begin
        int node;
        node       = 0;
        new_select = select;
        for (int l = 0; l < way_bits; l++) begin
            new_select[node] = ~touch_way[way_bits-1-l];
            node = 2 * node + 1 + int'(touch_way[way_bits-1-l]);
        end
    end

endmodule

/* source/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic            clk,
    input  logic            resetn,
    input  logic            req,
    input  bus_pkg::addr_t  addr,
    input  bus_pkg::wrten_t wrten,
    input  bus_pkg::word_t  wdata,
    output logic            addr_ok,
    output logic            data_ok,
    output bus_pkg::word_t  rdata,
    output logic            mem_valid,
    output logic            mem_write,
    output bus_pkg::addr_t  mem_addr,
    output bus_pkg::len_t   mem_len,
    output bus_pkg::word_t  mem_wdata,
    output bus_pkg::wrten_t mem_wstrb,
    input  logic            mem_okay,
    input  bus_pkg::word_t  mem_rdata,
    input  logic            mem_last
);
    import bus_pkg::*;
    import cache_pkg::*;

    typedef enum logic [1:0] {
        idle,
        refill,
        writeback
    } state_t;

    line_addr_t req_addr;

    record_t records [num_sets][num_ways];
    select_t selects [num_sets];

    bundle_t tags;
    bundle_t tag_wdata;
    index_t  tag_index_q;
    logic    tag_stale_q;
    logic    tags_ok;
    logic [num_ways-1:0] tag_we;

    logic [num_ways-1:0] hit_bits;
    logic    req_hit;
    way_t    hit_way;
    way_t    victim_way;
    select_t new_select;

    state_t  state;
    tag_t    miss_tag;
    index_t  miss_index;
    way_t    miss_way;
    offset_t miss_start;
    offset_t miss_offset;
    logic [num_words-1:0] arrived;
    record_t victim_record;
    tag_t    victim_tag;

    // victim words show up one cycle after their refill beat
    line_t   victim_buf;
    logic    vbuf_we;
    offset_t vbuf_offset;
    word_t   refill_old;
    wrten_t  refill_we;

    logic in_miss, word_ready, miss_avail, to_hit, to_miss;

    assign req_addr = addr;

    // tags read last cycle are usable if the index held and no tag was written
    assign tags_ok   = tag_index_q == req_addr.index && !tag_stale_q;
    assign tag_we    = {{(num_ways - 1){1'b0}}, to_miss} << victim_way;
    assign tag_wdata = {num_ways{req_addr.tag}};

    dual_port_ram #(
        .payload_t (bundle_t),
        .depth_bits(index_bits),
        .lanes     (num_ways)
    ) i_tag_ram (
        .clk    (clk),
        .en_a   (1'b1),
        .we_a   (tag_we),
        .addr_a (req_addr.index),
        .wdata_a(tag_wdata),
        .rdata_a(tags),
        .en_b   (1'b0),
        .we_b   ('0),
        .addr_b ('0),
        .wdata_b('0),
        .rdata_b()
    );

    for (genvar i = 0; i < num_ways; i++) begin : g_hit
        assign hit_bits[i] = records[req_addr.index][i].valid && tags[i] == req_addr.tag;
    end

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (hit_bits[i]) begin
                hit_way = way_t'(i);
            end
        end
    end

    plru_tree i_plru (
        .select    (selects[req_addr.index]),
        .victim    (victim_way),
        .touch_way (hit_way),
        .new_select(new_select)
    );

    assign req_hit = tags_ok && |hit_bits;

    // during refill only arrived words of the refilling line may hit
    assign in_miss    = state != idle && req_addr.tag == miss_tag &&
                        req_addr.index == miss_index;
    assign word_ready = in_miss ? arrived[req_addr.offset] : state != refill;
    assign miss_avail = state == idle || (state == writeback && mem_okay && mem_last);

    assign to_hit  = req && req_hit && word_ready;
    assign to_miss = req && tags_ok && !req_hit && miss_avail;
    assign addr_ok = to_hit;

    assign refill_we = (state == refill && mem_okay) ? full_strobe : '0;

    dual_port_ram #(
        .payload_t (word_t),
        .depth_bits(data_depth_bits),
        .lanes     (data_bytes)
    ) i_data_ram (
        .clk    (clk),
        .en_a   (to_hit),
        .we_a   (wrten),
        .addr_a ({hit_way, req_addr.index, req_addr.offset}),
        .wdata_a(wdata),
        .rdata_a(rdata),
        .en_b   (state == refill),
        .we_b   (refill_we),
        .addr_b ({miss_way, miss_index, miss_offset}),
        .wdata_b(mem_rdata),
        .rdata_b(refill_old)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < num_sets; s++) begin
                selects[s] <= '0;
                for (int w = 0; w < num_ways; w++) begin
                    records[s][w] <= '0;
                end
            end
            tag_stale_q <= 1'b1;
        end else begin
            tag_stale_q <= to_miss;
            tag_index_q <= req_addr.index;
            if (to_hit) begin
                selects[req_addr.index] <= new_select;
                if (|wrten) begin
                    records[req_addr.index][hit_way].dirty <= 1'b1;
                end
            end
            if (to_miss) begin
                records[req_addr.index][victim_way] <= '{valid: 1'b1, dirty: 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= idle;
            vbuf_we <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            data_ok     <= to_hit;
            vbuf_we     <= state == refill && mem_okay;
            vbuf_offset <= miss_offset;
            case (state)
                refill: begin
                    if (mem_okay) begin
                        arrived[miss_offset] <= 1'b1;
                        miss_offset <= miss_offset + 1'b1;
                    end
                    if (mem_okay && mem_last) begin
                        state    <= (victim_record.valid && victim_record.dirty) ?
                                    writeback : idle;
                        // writeback goes out under the victim tag
                        miss_tag <= victim_tag;
                    end
                end
                writeback: begin
                    if (mem_okay) begin
                        miss_offset <= miss_offset + 1'b1;
                    end
                    if (mem_okay && mem_last) begin
                        state <= idle;
                    end
                end
                default: begin
                end
            endcase
            // may override the end of a writeback
            if (to_miss) begin
                state         <= refill;
                miss_tag      <= req_addr.tag;
                miss_index    <= req_addr.index;
                miss_way      <= victim_way;
                miss_start    <= req_addr.offset;
                miss_offset   <= req_addr.offset;
                arrived       <= '0;
                victim_record <= records[req_addr.index][victim_way];
                victim_tag    <= tags[victim_way];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vbuf_we) begin
            victim_buf[vbuf_offset] <= refill_old;
        end
    end

    // both bursts start at the missed word and wrap back to it
    assign mem_valid = state != idle;
    assign mem_write = state == writeback;
    assign mem_addr  = {miss_tag, miss_index, miss_start, {align_bits{1'b0}}};
    assign mem_len   = len_t'(num_words - 1);
    assign mem_wdata = victim_buf[miss_offset];
    assign mem_wstrb = full_strobe;

endmodule

/* source/uncached_port.sv */
`timescale 1ns/1ps

module uncached_port (
    input  logic            clk,
    input  logic            resetn,
    input  logic            req,
    input  bus_pkg::addr_t  addr,
    input  bus_pkg::wrten_t wrten,
    input  bus_pkg::word_t  wdata,
    output logic            addr_ok,
    output logic            data_ok,
    output bus_pkg::word_t  rdata,
    output logic            mem_valid,
    output logic            mem_write,
    output bus_pkg::addr_t  mem_addr,
    output bus_pkg::len_t   mem_len,
    output bus_pkg::word_t  mem_wdata,
    output bus_pkg::wrten_t mem_wstrb,
    input  logic            mem_okay,
    input  bus_pkg::word_t  mem_rdata,
    input  logic            mem_last
);
    import bus_pkg::*;

    logic is_write;

    assign is_write = |wrten;

    // core fields are held until addr_ok, so they drive the bus directly
    assign mem_valid = req;
    assign mem_write = is_write;
    assign mem_addr  = addr;
    assign mem_len   = '0;
    assign mem_wdata = wdata;
    assign mem_wstrb = is_write ? wrten : full_strobe;

    // single beat, so the okay beat is also the last
    assign addr_ok = req && mem_okay && mem_last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
            if (addr_ok && !is_write) begin
                rdata <= mem_rdata;
            end
        end
    end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic            clk,
    input  logic            resetn,
    input  logic            c_mem_valid,
    input  logic            c_mem_write,
    input  bus_pkg::addr_t  c_mem_addr,
    input  bus_pkg::len_t   c_mem_len,
    input  bus_pkg::word_t  c_mem_wdata,
    input  bus_pkg::wrten_t c_mem_wstrb,
    output logic            c_mem_okay,
    output bus_pkg::word_t  c_mem_rdata,
    output logic            c_mem_last,
    input  logic            u_mem_valid,
    input  logic            u_mem_write,
    input  bus_pkg::addr_t  u_mem_addr,
    input  bus_pkg::len_t   u_mem_len,
    input  bus_pkg::word_t  u_mem_wdata,
    input  bus_pkg::wrten_t u_mem_wstrb,
    output logic            u_mem_okay,
    output bus_pkg::word_t  u_mem_rdata,
    output logic            u_mem_last,
    output logic            mem_valid,
    output logic            mem_write,
    output bus_pkg::addr_t  mem_addr,
    output bus_pkg::len_t   mem_len,
    output bus_pkg::word_t  mem_wdata,
    output bus_pkg::wrten_t mem_wstrb,
    input  logic            mem_okay,
    input  bus_pkg::word_t  mem_rdata,
    input  logic            mem_last
);
    import bus_pkg::*;

    logic held_q;
    logic held_u_q;
    logic pick_u;
    logic done;

    // idle grant is immediate, cache first
    assign pick_u = held_q ? held_u_q : !c_mem_valid;
    assign done   = mem_okay && mem_last;

    assign mem_valid = pick_u ? u_mem_valid : c_mem_valid;
    assign mem_write = pick_u ? u_mem_write : c_mem_write;
    assign mem_addr  = pick_u ? u_mem_addr  : c_mem_addr;
    assign mem_len   = pick_u ? u_mem_len   : c_mem_len;
    assign mem_wdata = pick_u ? u_mem_wdata : c_mem_wdata;
    assign mem_wstrb = pick_u ? u_mem_wstrb : c_mem_wstrb;

    assign c_mem_okay  = !pick_u && mem_okay;
    assign c_mem_last  = !pick_u && mem_last;
    assign c_mem_rdata = pick_u ? '0 : mem_rdata;
    assign u_mem_okay  = pick_u && mem_okay;
    assign u_mem_last  = pick_u && mem_last;
    assign u_mem_rdata = pick_u ? mem_rdata : '0;

    // keep the grant until the last beat is accepted
    always_ff @(posedge clk) begin
        if (resetn) begin
            held_q   <= 1'b0;
            held_u_q <= 1'b0;
        end else if (mem_valid && !done) begin
            held_q   <= 1'b1;
            held_u_q <= pick_u;
        end else if (done) begin
            held_q <= 1'b0;
        end
    end

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic            clk,
    input  logic            resetn,
    input  logic            req,
    input  bus_pkg::addr_t  addr,
    input  bus_pkg::wrten_t wrten,
    input  bus_pkg::word_t  wdata,
    output logic            addr_ok,
    output logic            data_ok,
    output bus_pkg::word_t  rdata,
    output logic            mem_valid,
    output logic            mem_write,
    output bus_pkg::addr_t  mem_addr,
    output bus_pkg::len_t   mem_len,
    output bus_pkg::word_t  mem_wdata,
    output bus_pkg::wrten_t mem_wstrb,
    input  logic            mem_okay,
    input  bus_pkg::word_t  mem_rdata,
    input  logic            mem_last
);
    import bus_pkg::*;

    logic   is_uncached, from_u_q;
    logic   c_req, c_addr_ok, c_data_ok;
    logic   u_req, u_addr_ok, u_data_ok;
    word_t  c_rdata, u_rdata;
    addr_t  u_addr;

    logic   c_mem_valid, c_mem_write, c_mem_okay, c_mem_last;
    addr_t  c_mem_addr;
    len_t   c_mem_len;
    word_t  c_mem_wdata, c_mem_rdata;
    wrten_t c_mem_wstrb;

    logic   u_mem_valid, u_mem_write, u_mem_okay, u_mem_last;
    addr_t  u_mem_addr;
    len_t   u_mem_len;
    word_t  u_mem_wdata, u_mem_rdata;
    wrten_t u_mem_wstrb;

    assign is_uncached = addr[uncached_bit];
    assign c_req       = req && !is_uncached;
    assign u_req       = req && is_uncached;

    // the bypass sees the same memory as the cached window
    assign u_addr = addr & ~(addr_t'(1) << uncached_bit);

    assign addr_ok = is_uncached ? u_addr_ok : c_addr_ok;
    assign data_ok = from_u_q ? u_data_ok : c_data_ok;
    assign rdata   = from_u_q ? u_rdata : c_rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            from_u_q <= 1'b0;
        end else if (req && addr_ok) begin
            from_u_q <= is_uncached;
        end
    end

    dcache i_dcache (
        .clk      (clk),
        .resetn   (resetn),
        .req      (c_req),
        .addr     (addr),
        .wrten    (wrten),
        .wdata    (wdata),
        .addr_ok  (c_addr_ok),
        .data_ok  (c_data_ok),
        .rdata    (c_rdata),
        .mem_valid(c_mem_valid),
        .mem_write(c_mem_write),
        .mem_addr (c_mem_addr),
        .mem_len  (c_mem_len),
        .mem_wdata(c_mem_wdata),
        .mem_wstrb(c_mem_wstrb),
        .mem_okay (c_mem_okay),
        .mem_rdata(c_mem_rdata),
        .mem_last (c_mem_last)
    );

    uncached_port i_uncached (
        .clk      (clk),
        .resetn   (resetn),
        .req      (u_req),
        .addr     (u_addr),
        .wrten    (wrten),
        .wdata    (wdata),
        .addr_ok  (u_addr_ok),
        .data_ok  (u_data_ok),
        .rdata    (u_rdata),
        .mem_valid(u_mem_valid),
        .mem_write(u_mem_write),
        .mem_addr (u_mem_addr),
        .mem_len  (u_mem_len),
        .mem_wdata(u_mem_wdata),
        .mem_wstrb(u_mem_wstrb),
        .mem_okay (u_mem_okay),
        .mem_rdata(u_mem_rdata),
        .mem_last (u_mem_last)
    );

    mem_arbiter i_arbiter (
        .clk        (clk),
        .resetn     (resetn),
        .c_mem_valid(c_mem_valid),
        .c_mem_write(c_mem_write),
        .c_mem_addr (c_mem_addr),
        .c_mem_len  (c_mem_len),
        .c_mem_wdata(c_mem_wdata),
        .c_mem_wstrb(c_mem_wstrb),
        .c_mem_okay (c_mem_okay),
        .c_mem_rdata(c_mem_rdata),
        .c_mem_last (c_mem_last),
        .u_mem_valid(u_mem_valid),
        .u_mem_write(u_mem_write),
        .u_mem_addr (u_mem_addr),
        .u_mem_len  (u_mem_len),
        .u_mem_wdata(u_mem_wdata),
        .u_mem_wstrb(u_mem_wstrb),
        .u_mem_okay (u_mem_okay),
        .u_mem_rdata(u_mem_rdata),
        .u_mem_last (u_mem_last),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_len    (mem_len),
        .mem_wdata  (mem_wdata),
        .mem_wstrb  (mem_wstrb),
        .mem_okay   (mem_okay),
        .mem_rdata  (mem_rdata),
        .mem_last   (mem_last)
    );

endmodule

/* tests/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
    input  logic            clk,
    input  logic            resetn,
    input  logic            stall,
    input  logic            mem_valid,
    input  logic            mem_write,
    input  bus_pkg::addr_t  mem_addr,
    input  bus_pkg::len_t   mem_len,
    input  bus_pkg::word_t  mem_wdata,
    input  bus_pkg::wrten_t mem_wstrb,
    output logic            mem_okay,
    output bus_pkg::word_t  mem_rdata,
    output logic            mem_last,
    output logic            wr_fire,
    output logic [11:0]     wr_word,
    output bus_pkg::word_t  wr_value,
    output logic            protocol_error
);
    import bus_pkg::*;

    localparam int depth_bits = 12;

    word_t mem [2**depth_bits];

    logic                  active;
    logic [1:0]            beat;
    logic [depth_bits-1:0] beat_word;
    word_t                 merged;
    logic [addr_width+len_width:0] start_fields;

    // bursts wrap inside the 4-word line, starting at the addressed word
    assign beat_word = {mem_addr[depth_bits+1:4], mem_addr[3:2] + beat};

    assign mem_okay  = mem_valid && !stall;
    assign mem_last  = beat == mem_len;
    assign mem_rdata = mem[beat_word];

    always_comb begin
        merged = mem[beat_word];
        for (int b = 0; b < data_bytes; b++) begin
            if (mem_wstrb[b]) begin
                merged[8*b +: 8] = mem_wdata[8*b +: 8];
            end
        end
    end

    task automatic flag_violation(input string msg);
        $display("memory model: protocol violation at %0t, %s", $time, msg);
        protocol_error <= 1'b1;
    endtask

    always @(posedge clk) begin
        wr_fire <= 1'b0;
        if (resetn) begin
            active         <= 1'b0;
            beat           <= '0;
            protocol_error <= 1'b0;
        end else begin
            if (mem_valid && mem_len != 0 && mem_len != 3) begin
                flag_violation($sformatf("burst of %0d beats, only 1 or 4 are allowed",
                                         int'(mem_len) + 1));
            end
            if (active && !mem_valid) begin
                flag_violation("valid dropped before the last beat of a burst");
            end
            if (active && mem_valid && {mem_write, mem_len, mem_addr} != start_fields) begin
                flag_violation("request fields changed in the middle of a burst");
            end
            if (mem_valid && !active) begin
                start_fields <= {mem_write, mem_len, mem_addr};
            end
            if (mem_okay) begin
                if (mem_write) begin
                    mem[beat_word] <= merged;
                    wr_fire        <= 1'b1;
                    wr_word        <= beat_word;
                    wr_value       <= merged;
                end
                if (mem_last) begin
                    active <= 1'b0;
                    beat   <= '0;
                end else begin
                    active <= 1'b1;
                    beat   <= beat + 1'b1;
                end
            end else if (mem_valid) begin
                active <= 1'b1;
            end
        end
    end

endmodule

/* tests/tb_dcache_top.sv */
`timescale 1ns/1ps

module tb_dcache_top;
    import bus_pkg::*;

    localparam int num_accesses      = 3000;
    localparam int sweep_loads       = 32;
    localparam int cycles_per_access = 40;
    localparam int timeout_cycles    = (num_accesses + sweep_loads) * cycles_per_access;
    localparam int reset_cycles      = 16;
    localparam int mem_words         = 4096;
    localparam int window_words      = 64;
    // word indices of the uncached window and of the eviction sweep
    localparam int uncached_base     = 256;
    localparam int sweep_base        = 512;
    localparam logic [15:0] seed     = 16'd35293;

    logic   clk;
    logic   resetn;
    logic   req;
    addr_t  addr;
    wrten_t wrten;
    word_t  wdata;
    logic   addr_ok;
    logic   data_ok;
    word_t  rdata;

    logic   mem_valid;
    logic   mem_write;
    addr_t  mem_addr;
    len_t   mem_len;
    word_t  mem_wdata;
    wrten_t mem_wstrb;
    logic   mem_okay;
    word_t  mem_rdata;
    logic   mem_last;

    logic        stall;
    logic        wr_fire;
    logic [11:0] wr_word;
    word_t       wr_value;
    logic        protocol_error;

    logic [15:0] stim_lfsr = seed;
    logic [15:0] gap_lfsr  = seed;

    // reference model state
    word_t       shadow [mem_words];
    logic        accepted_q;
    logic        load_q;
    word_t       load_value_q;
    addr_t       load_addr_q;
    logic [11:0] pending_word [$];
    word_t       pending_value [$];
    int          accept_count  = 0;
    int          data_ok_count = 0;
    int          cycle_count   = 0;

    dcache_top i_dut (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .addr     (addr),
        .wrten    (wrten),
        .wdata    (wdata),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .mem_valid(mem_valid),
        .mem_write(mem_write),
        .mem_addr (mem_addr),
        .mem_len  (mem_len),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .mem_okay (mem_okay),
        .mem_rdata(mem_rdata),
        .mem_last (mem_last)
    );

    tb_mem_model i_mem (
        .clk           (clk),
        .resetn        (resetn),
        .stall         (stall),
        .mem_valid     (mem_valid),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_len       (mem_len),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_okay      (mem_okay),
        .mem_rdata     (mem_rdata),
        .mem_last      (mem_last),
        .wr_fire       (wr_fire),
        .wr_word       (wr_word),
        .wr_value      (wr_value),
        .protocol_error(protocol_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_pattern(input int unsigned index);
        return (word_t'(index) * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t data, input wrten_t be);
        word_t v;
        v = old;
        for (int b = 0; b < data_bytes; b++) begin
            if (be[b]) begin
                v[8*b +: 8] = data[8*b +: 8];
            end
        end
        return v;
    endfunction

    // 64 cached words over sets 0 and 1 only, eight lines per set
    function automatic addr_t cached_addr(input logic [5:0] sel);
        return addr_t'({sel[5:3], 1'b0, sel[2], sel[1:0]}) << 2;
    endfunction

    function automatic addr_t uncached_addr(input logic [5:0] sel);
        return (addr_t'(uncached_base + sel) << 2) | (addr_t'(1) << uncached_bit);
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("** Error at %0t: %s is %h, expected %h",
                                        $time, what, got, expected));
        end
    endtask

    task automatic send_access(input addr_t a, input wrten_t be, input word_t d);
        req   <= 1'b1;
        addr  <= a;
        wrten <= be;
        wdata <= d;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
    endtask

    task automatic record_access();
        logic [11:0] idx;
        idx = addr[13:2];
        accept_count++;
        if (wrten == '0) begin
            load_q       = 1'b1;
            load_value_q = shadow[idx];
            load_addr_q  = addr;
        end else begin
            load_q      = 1'b0;
            shadow[idx] = merge_lanes(shadow[idx], wdata, wrten);
            if (addr[uncached_bit]) begin
                pending_word.push_back(idx);
                pending_value.push_back(shadow[idx]);
            end
        end
    endtask

    // each memory write into the uncached window matches the oldest pending store
    task automatic check_uncached_write();
        logic [11:0] exp_word;
        word_t       exp_value;
        if (wr_fire && wr_word >= uncached_base && wr_word < uncached_base + window_words) begin
            if (pending_word.size() == 0) begin
                stop_with_failure($sformatf("memory write to uncached word %0d with no store",
                                            wr_word));
            end else begin
                exp_word  = pending_word.pop_front();
                exp_value = pending_value.pop_front();
                check_value("uncached store word", word_t'(wr_word), word_t'(exp_word));
                check_value("uncached store value", wr_value, exp_value);
            end
        end
    endtask

    always @(posedge clk) begin
        gap_lfsr = lfsr_step(gap_lfsr);
        gap_lfsr = lfsr_step(gap_lfsr);
        // a gap in about one beat of four
        stall <= gap_lfsr[1] & gap_lfsr[0];
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            stop_with_failure($sformatf("timeout, the run did not finish within %0d cycles",
                                        timeout_cycles));
        end
    end

    always @(posedge clk) begin
        if (resetn) begin
            accepted_q = 1'b0;
            load_q     = 1'b0;
        end else begin
            if (protocol_error) begin
                stop_with_failure("memory model saw a memory bus protocol violation");
            end
            check_value("data_ok one cycle after acceptance", word_t'(data_ok),
                        word_t'(accepted_q));
            if (data_ok) begin
                data_ok_count++;
                if (load_q) begin
                    check_value($sformatf("rdata of load from %h", load_addr_q), rdata,
                                load_value_q);
                end
            end
            check_uncached_write();
            accepted_q = req && addr_ok;
            if (accepted_q) begin
                record_access();
            end
        end
    end

    initial begin
        logic [1:0] pick;
        logic       is_write;
        logic [5:0] sel;
        wrten_t     lanes;
        wrten_t     be;
        word_t      value;
        addr_t      a;

        req    = 1'b0;
        addr   = '0;
        wrten  = '0;
        wdata  = '0;
        resetn = 1'b1;
        stall  = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i]    = fill_pattern(i);
            i_mem.mem[i] = fill_pattern(i);
        end

        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);

        for (int n = 0; n < num_accesses; n++) begin
            pick     = 2'(take_bits(2));
            is_write = take_bits(1);
            sel      = 6'(take_bits(6));
            lanes    = wrten_t'(take_bits(4));
            value    = take_bits(32);
            if (!is_write) begin
                be = '0;
            end else if (lanes == '0) begin
                be = '1;
            end else begin
                be = lanes;
            end
            a = (pick == 0) ? uncached_addr(sel) : cached_addr(sel);
            send_access(a, be, value);
            if (take_bits(2) == 0) begin
                req <= 1'b0;
                @(posedge clk);
            end
        end

        // two passes of fresh lines push every window line out
        for (int pass = 0; pass < 2; pass++) begin
            for (int way = 0; way < 4; way++) begin
                for (int set = 0; set < 4; set++) begin
                    a = addr_t'(sweep_base + (pass * 4 + way) * 16 + set * 4) << 2;
                    send_access(a, '0, '0);
                end
            end
        end
        req <= 1'b0;
        @(posedge clk);
        while (mem_valid) begin
            @(posedge clk);
        end
        @(posedge clk);

        check_value("uncached stores not seen in memory", word_t'(pending_word.size()), '0);
        check_value("accepted accesses", word_t'(accept_count),
                    word_t'(num_accesses + sweep_loads));
        check_value("data_ok pulses", word_t'(data_ok_count),
                    word_t'(num_accesses + sweep_loads));
        for (int i = 0; i < mem_words; i++) begin
            check_value($sformatf("memory word %0d", i), i_mem.mem[i], shadow[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tb.f */
source/bus_pkg.sv
source/cache_pkg.sv
source/dual_port_ram.sv
source/plru_tree.sv
source/dcache.sv
source/uncached_port.sv
source/mem_arbiter.sv
source/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache_top.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - source/bus_pkg.sv
  - source/cache_pkg.sv
  - source/dual_port_ram.sv
  - source/plru_tree.sv
  - source/dcache.sv
  - source/uncached_port.sv
  - source/mem_arbiter.sv
  - source/dcache_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_dcache_top.sv
